//--- pagerank_cfg.svh
// PageRank compute unit configuration: datapath widths and FIFO sizing

`ifndef PAGERANK_CFG_SVH
`define PAGERANK_CFG_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

// Vertex id and vertex count
`define PR_VERTEX_W 32
// Out-degree, edge index and edge count
`define PR_EDGE_W 32
// Fixed-point contribution and running sum
`define PR_RANK_W 32

////////////////////////////////////////////////////////////
// Buffer sizing
////////////////////////////////////////////////////////////

// Burst guard in front of the vertex FSM
`define PR_VERTEX_FIFO_DEPTH 16
`define PR_CMD_FIFO_DEPTH 8
// Free slots left when the command FIFO reports almost full
`define PR_CMD_ALFULL_MARGIN 2

`endif

//--- pagerank_job_pkg.sv
// PageRank job types: incoming vertex jobs and finished rank writes

`include "pagerank_cfg.svh"

package pagerank_job_pkg;

	////////////////////////////////////////////////////////////
	// Vertex side
	////////////////////////////////////////////////////////////

	// One vertex to process, edges_idx is the first edge-array index
	typedef struct packed {
		logic                   valid;
		logic [`PR_VERTEX_W-1:0] vertex_id;
		logic [`PR_EDGE_W-1:0]   out_degree;
		logic [`PR_EDGE_W-1:0]   edges_idx;
	} vertex_job_t;

	////////////////////////////////////////////////////////////
	// Result side
	////////////////////////////////////////////////////////////

	// Summed contributions of a finished vertex
	typedef struct packed {
		logic                   valid;
		logic [`PR_VERTEX_W-1:0] vertex_id;
		logic [`PR_RANK_W-1:0]   rank_sum;
	} rank_write_t;

endpackage

//--- pagerank_mem_pkg.sv
// PageRank memory-side types: read commands, edge data and buffer flags

`include "pagerank_cfg.svh"

package pagerank_mem_pkg;

	////////////////////////////////////////////////////////////
	// Read path
	////////////////////////////////////////////////////////////

	// Edge-array read, tagged with the vertex that owns it
	typedef struct packed {
		logic                   valid;
		logic [`PR_EDGE_W-1:0]   address;
		logic [`PR_VERTEX_W-1:0] tag;
	} read_cmd_t;

	// One neighbour contribution coming back from memory
	typedef struct packed {
		logic                 valid;
		logic [`PR_RANK_W-1:0] rank;
	} edge_data_t;

	////////////////////////////////////////////////////////////
	// Buffer flags
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic valid;
		logic empty;
		logic full;
		logic alfull;
	} buffer_status_t;

endpackage

//--- job_fifo.sv
// Show-ahead synchronous FIFO carrying any packed payload type

`timescale 1ns/1ps

module job_fifo #(
	parameter type payload_t     = logic [7:0],
	parameter int  DEPTH         = 16,
	parameter int  ALFULL_MARGIN = 2
) (
	input  logic                             clock,
	input  logic                             rstn,
	input  logic                             push,
	input  payload_t                         data_in,
	input  logic                             pop,
	output payload_t                         data_out,
	output pagerank_mem_pkg::buffer_status_t status
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// A pop frees a slot in the same edge, so full still accepts then
	assign do_pop  = pop && !status.empty;
	assign do_push = push && (!status.full || do_pop);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	// Head is visible without a read cycle; zeroed while empty
	assign data_out = status.empty ? payload_t'('0) : mem[rd_ptr];

	assign status.empty  = (count == '0);
	assign status.valid  = !status.empty;
	assign status.full   = (count == CNT_W'(DEPTH));
	assign status.alfull = (count >= CNT_W'(DEPTH - ALFULL_MARGIN));

endmodule

//--- edge_progress_counter.sv
// Tracks issued reads and returned data of one vertex against its out-degree

`timescale 1ns/1ps
`include "pagerank_cfg.svh"

module edge_progress_counter (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  start,
	input  logic [`PR_EDGE_W-1:0] out_degree,
	input  logic                  issue,
	input  logic                  edge_data_valid,
	output logic [`PR_EDGE_W-1:0] issue_index,
	output logic                  issue_done,
	output logic                  data_done,
	output logic [`PR_EDGE_W-1:0] edge_total
);

	logic [`PR_EDGE_W-1:0] degree_latched;
	logic [`PR_EDGE_W-1:0] data_count;

	////////////////////////////////////////////////////////////
	// Per-vertex progress
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			degree_latched <= '0;
			issue_index    <= '0;
			data_count     <= '0;
		end else if (start) begin
			degree_latched <= out_degree;
			issue_index    <= '0;
			data_count     <= '0;
		end else begin
			if (issue)
				issue_index <= issue_index + 1'b1;
			if (edge_data_valid)
				data_count <= data_count + 1'b1;
		end
	end

	assign issue_done = (issue_index == degree_latched);
	assign data_done  = (data_count == degree_latched);

	////////////////////////////////////////////////////////////
	// Run-wide edge total
	////////////////////////////////////////////////////////////

	// Counts every contribution received, never cleared by start
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_total <= '0;
		end else if (edge_data_valid) begin
			edge_total <= edge_total + 1'b1;
		end
	end

endmodule

//--- rank_accumulator.sv
// Fixed-point sum of the neighbour contributions of the current vertex

`timescale 1ns/1ps
`include "pagerank_cfg.svh"

module rank_accumulator (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         start,
	input  logic                         collecting,
	input  pagerank_mem_pkg::edge_data_t edge_data,
	output logic [`PR_RANK_W-1:0]        rank_sum
);

	logic add_en;

	// Only contributions that arrive while a vertex is open count
	assign add_en = collecting && edge_data.valid;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rank_sum <= '0;
		end else if (start) begin
			rank_sum <= '0;
		end else if (add_en) begin
			// Wraps modulo 2^PR_RANK_W
			rank_sum <= rank_sum + edge_data.rank;
		end
	end

endmodule

//--- vertex_control_fsm.sv
// Vertex FSM: takes a job, issues its edge reads and emits the rank write

`timescale 1ns/1ps
`include "pagerank_cfg.svh"

module vertex_control_fsm (
	input  logic                             clock,
	input  logic                             rstn,
	input  logic                             enabled_in,
	input  pagerank_job_pkg::vertex_job_t    job_head,
	input  pagerank_mem_pkg::buffer_status_t job_status,
	output logic                             job_pop,
	input  pagerank_mem_pkg::buffer_status_t cmd_status,
	output logic                             cmd_push,
	output pagerank_mem_pkg::read_cmd_t      cmd_data,
	output logic                             start,
	output logic [`PR_EDGE_W-1:0]            out_degree,
	output logic                             collecting,
	output logic                             issue,
	input  logic [`PR_EDGE_W-1:0]            issue_index,
	input  logic                             issue_done,
	input  logic                             data_done,
	input  logic [`PR_RANK_W-1:0]            rank_sum,
	output pagerank_job_pkg::rank_write_t    rank_write_out,
	output logic [`PR_VERTEX_W-1:0]          vertex_num_counter
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_ISSUE,
		ST_WAIT,
		ST_WRITE
	} state_t;

	state_t state;
	state_t state_next;

	logic [`PR_VERTEX_W-1:0] vertex_id_latched;
	logic [`PR_EDGE_W-1:0]   edges_idx_latched;

	////////////////////////////////////////////////////////////
	// State sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= ST_IDLE;
		end else if (enabled_in) begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (!job_status.empty)
					state_next = ST_LOAD;
			end
			ST_LOAD: begin
				// Nothing to fetch for an isolated vertex
				if (job_head.out_degree == '0)
					state_next = ST_WRITE;
				else
					state_next = ST_ISSUE;
			end
			ST_ISSUE: begin
				if (issue_done)
					state_next = ST_WAIT;
			end
			ST_WAIT: begin
				if (data_done)
					state_next = ST_WRITE;
			end
			ST_WRITE: state_next = ST_IDLE;
			default:  state_next = ST_IDLE;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Job capture
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (job_pop) begin
			vertex_id_latched <= job_head.vertex_id;
			edges_idx_latched <= job_head.edges_idx;
		end
	end

	// LOAD pops the head and clears the counter and accumulator together
	assign job_pop    = enabled_in && (state == ST_LOAD);
	assign start      = job_pop;
	assign out_degree = job_head.out_degree;

	////////////////////////////////////////////////////////////
	// Read command issue
	////////////////////////////////////////////////////////////

	assign issue = enabled_in && (state == ST_ISSUE) && !issue_done
		&& !cmd_status.alfull && !cmd_status.full;

	assign cmd_push         = issue;
	assign cmd_data.valid   = issue;
	assign cmd_data.address = edges_idx_latched + issue_index;
	assign cmd_data.tag     = vertex_id_latched;

	// Data may come back while later commands are still going out
	assign collecting = (state == ST_ISSUE) || (state == ST_WAIT);

	////////////////////////////////////////////////////////////
	// Rank write and vertex total
	////////////////////////////////////////////////////////////

	assign rank_write_out.valid     = enabled_in && (state == ST_WRITE);
	assign rank_write_out.vertex_id = vertex_id_latched;
	assign rank_write_out.rank_sum  = rank_sum;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_num_counter <= '0;
		end else if (rank_write_out.valid) begin
			vertex_num_counter <= vertex_num_counter + 1'b1;
		end
	end

endmodule

//--- cu_vertex_pagerank.sv
// PageRank vertex compute unit: job buffer, vertex FSM, read command queue and sum

`timescale 1ns/1ps
`include "pagerank_cfg.svh"

module cu_vertex_pagerank (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enabled_in,
	input  pagerank_job_pkg::vertex_job_t vertex_job,
	output logic                          vertex_job_request,
	input  logic                          read_buffer_alfull,
	input  logic                          read_command_bus_grant,
	output logic                          read_command_bus_request,
	output pagerank_mem_pkg::read_cmd_t   read_command_out,
	input  pagerank_mem_pkg::edge_data_t  edge_data_in,
	output pagerank_job_pkg::rank_write_t rank_write_out,
	output logic [`PR_VERTEX_W-1:0]       vertex_num_counter,
	output logic [`PR_EDGE_W-1:0]         edge_num_counter
);

	pagerank_job_pkg::vertex_job_t    vertex_head;
	pagerank_mem_pkg::buffer_status_t vertex_status;
	pagerank_mem_pkg::buffer_status_t cmd_status;
	pagerank_mem_pkg::read_cmd_t      cmd_data;

	logic                  job_pop;
	logic                  cmd_push;
	logic                  start;
	logic                  collecting;
	logic                  issue;
	logic                  issue_done;
	logic                  data_done;
	logic [`PR_EDGE_W-1:0] out_degree;
	logic [`PR_EDGE_W-1:0] issue_index;
	logic [`PR_RANK_W-1:0] rank_sum;

	// Ask for more jobs only once the burst guard has drained
	assign vertex_job_request       = vertex_status.empty;
	assign read_command_bus_request = !cmd_status.empty && !read_buffer_alfull;

	////////////////////////////////////////////////////////////
	// Buffers
	////////////////////////////////////////////////////////////

	job_fifo #(
		.payload_t(pagerank_job_pkg::vertex_job_t),
		.DEPTH    (`PR_VERTEX_FIFO_DEPTH)
	) u_vertex_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (vertex_job.valid),
		.data_in (vertex_job),
		.pop     (job_pop),
		.data_out(vertex_head),
		.status  (vertex_status)
	);

	job_fifo #(
		.payload_t    (pagerank_mem_pkg::read_cmd_t),
		.DEPTH        (`PR_CMD_FIFO_DEPTH),
		.ALFULL_MARGIN(`PR_CMD_ALFULL_MARGIN)
	) u_cmd_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (cmd_push),
		.data_in (cmd_data),
		.pop     (read_command_bus_grant),
		.data_out(read_command_out),
		.status  (cmd_status)
	);

	////////////////////////////////////////////////////////////
	// Vertex processing
	////////////////////////////////////////////////////////////

	vertex_control_fsm u_fsm (
		.clock             (clock),
		.rstn              (rstn),
		.enabled_in        (enabled_in),
		.job_head          (vertex_head),
		.job_status        (vertex_status),
		.job_pop           (job_pop),
		.cmd_status        (cmd_status),
		.cmd_push          (cmd_push),
		.cmd_data          (cmd_data),
		.start             (start),
		.out_degree        (out_degree),
		.collecting        (collecting),
		.issue             (issue),
		.issue_index       (issue_index),
		.issue_done        (issue_done),
		.data_done         (data_done),
		.rank_sum          (rank_sum),
		.rank_write_out    (rank_write_out),
		.vertex_num_counter(vertex_num_counter)
	);

	edge_progress_counter u_counter (
		.clock          (clock),
		.rstn           (rstn),
		.start          (start),
		.out_degree     (out_degree),
		.issue          (issue),
		.edge_data_valid(edge_data_in.valid),
		.issue_index    (issue_index),
		.issue_done     (issue_done),
		.data_done      (data_done),
		.edge_total     (edge_num_counter)
	);

	rank_accumulator u_accumulator (
		.clock     (clock),
		.rstn      (rstn),
		.start     (start),
		.collecting(collecting),
		.edge_data (edge_data_in),
		.rank_sum  (rank_sum)
	);

endmodule

//--- cu_vertex_pagerank_assert.sv
// Protocol checks on the compute unit's read command bus and rank write strobe

`timescale 1ns/1ps

module cu_vertex_pagerank_assert (
	input logic clock,
	input logic rstn,
	input logic read_buffer_alfull,
	input logic read_command_bus_request,
	input logic read_command_bus_grant,
	input logic rank_write_valid
);

	////////////////////////////////////////////////////////////
	// Read command bus
	////////////////////////////////////////////////////////////

	// Downstream buffer nearly full, so no request may go out
	request_blocked_by_alfull: assert property (
		@(posedge clock) disable iff (!rstn)
		read_buffer_alfull |-> !read_command_bus_request
	) else $error("read command request high while the read buffer is almost full");

	grant_needs_request: assert property (
		@(posedge clock) disable iff (!rstn)
		read_command_bus_grant |-> read_command_bus_request
	) else $error("read command grant given without a pending request");

	////////////////////////////////////////////////////////////
	// Rank write strobe
	////////////////////////////////////////////////////////////

	write_single_cycle: assert property (
		@(posedge clock) disable iff (!rstn)
		rank_write_valid |=> !rank_write_valid
	) else $error("rank write strobe held for more than one cycle");

endmodule

bind cu_vertex_pagerank cu_vertex_pagerank_assert u_assert (
	.clock                   (clock),
	.rstn                    (rstn),
	.read_buffer_alfull      (read_buffer_alfull),
	.read_command_bus_request(read_command_bus_request),
	.read_command_bus_grant  (read_command_bus_grant),
	.rank_write_valid        (rank_write_out.valid)
);

//--- tb_cu_vertex_pagerank.sv
// Testbench for the PageRank vertex compute unit with memory responder and reference sums

`timescale 1ns/1ps
`include "pagerank_cfg.svh"

module tb_cu_vertex_pagerank;

	localparam int NUM_JOBS  = 16;
	localparam int MEM_DEPTH = 256;

	logic                          clock;
	logic                          rstn;
	logic                          enabled_in;
	pagerank_job_pkg::vertex_job_t vertex_job;
	logic                          vertex_job_request;
	logic                          read_buffer_alfull;
	logic                          read_command_bus_grant;
	logic                          read_command_bus_request;
	pagerank_mem_pkg::read_cmd_t   read_command_out;
	pagerank_mem_pkg::edge_data_t  edge_data_in;
	pagerank_job_pkg::rank_write_t rank_write_out;
	logic [`PR_VERTEX_W-1:0]       vertex_num_counter;
	logic [`PR_EDGE_W-1:0]         edge_num_counter;

	logic [`PR_RANK_W-1:0]         mem_model [MEM_DEPTH];
	pagerank_job_pkg::vertex_job_t jobs [NUM_JOBS];

	// Expected results in issue order, and reads waiting for their data
	pagerank_job_pkg::rank_write_t exp_writes [$];
	pagerank_mem_pkg::read_cmd_t   exp_cmds [$];
	logic [`PR_EDGE_W-1:0]         return_addr [$];
	int                            return_due [$];

	int   cycle = 0;
	int   cycle_limit = 1000000;
	int   err_count = 0;
	int   checks_done = 0;
	int   last_due = 0;
	int   alfull_cycles_left = 0;
	logic prev_write_valid = 1'b0;

	cu_vertex_pagerank u_dut (
		.clock                   (clock),
		.rstn                    (rstn),
		.enabled_in              (enabled_in),
		.vertex_job              (vertex_job),
		.vertex_job_request      (vertex_job_request),
		.read_buffer_alfull      (read_buffer_alfull),
		.read_command_bus_grant  (read_command_bus_grant),
		.read_command_bus_request(read_command_bus_request),
		.read_command_out        (read_command_out),
		.edge_data_in            (edge_data_in),
		.rank_write_out          (rank_write_out),
		.vertex_num_counter      (vertex_num_counter),
		.edge_num_counter        (edge_num_counter)
	);

	initial clock = 1'b0;
	always #2 clock = ~clock;

	////////////////////////////////////////////////////////////
	// Reference model and compare tasks
	////////////////////////////////////////////////////////////

	function automatic pagerank_job_pkg::vertex_job_t make_job(input int id, input int degree,
		input int first_edge);
		pagerank_job_pkg::vertex_job_t job;
		job.valid      = 1'b1;
		job.vertex_id  = id;
		job.out_degree = degree;
		job.edges_idx  = first_edge;
		return job;
	endfunction

	// Wrapped sum of the contributions over the vertex's edge range
	function automatic pagerank_job_pkg::rank_write_t compute_rank_write(
		input pagerank_job_pkg::vertex_job_t job);
		pagerank_job_pkg::rank_write_t result;
		logic [`PR_RANK_W-1:0]         sum;
		sum = '0;
		for (int e = 0; e < job.out_degree; e++)
			sum = sum + mem_model[job.edges_idx + e];
		result.valid     = 1'b1;
		result.vertex_id = job.vertex_id;
		result.rank_sum  = sum;
		return result;
	endfunction

	task automatic note_failure(input string what);
		checks_done++;
		err_count++;
		$display("ERROR at cycle %0d: %s", cycle, what);
	endtask

	task automatic check_rank_write(input pagerank_job_pkg::rank_write_t actual,
		input pagerank_job_pkg::rank_write_t expected);
		checks_done++;
		if (actual !== expected) begin
			err_count++;
			$display("MISMATCH rank_write_out: got id=%h sum=%h, expected id=%h sum=%h",
				actual.vertex_id, actual.rank_sum, expected.vertex_id, expected.rank_sum);
		end
	endtask

	task automatic check_read_cmd(input pagerank_mem_pkg::read_cmd_t actual,
		input pagerank_mem_pkg::read_cmd_t expected);
		checks_done++;
		if (actual !== expected) begin
			err_count++;
			$display("MISMATCH read_command_out: got addr=%h tag=%h, expected addr=%h tag=%h",
				actual.address, actual.tag, expected.address, expected.tag);
		end
	endtask

	task automatic check_count(input string name, input logic [`PR_VERTEX_W-1:0] actual,
		input logic [`PR_VERTEX_W-1:0] expected);
		checks_done++;
		if (actual !== expected) begin
			err_count++;
			$display("MISMATCH %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		checks_done++;
		if (actual !== expected) begin
			err_count++;
			$display("MISMATCH %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Memory responder, grant and almost-full driver
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin : responder
		logic hold;
		#1;
		hold = (alfull_cycles_left > 0);
		if (hold)
			alfull_cycles_left--;
		read_buffer_alfull = hold;
		// Grant follows the request, now and then withheld
		read_command_bus_grant = rstn && read_command_out.valid && !hold
			&& ($urandom_range(3, 0) != 0);
		if (rstn && return_due.size() != 0 && return_due[0] <= cycle) begin
			edge_data_in.valid = 1'b1;
			edge_data_in.rank  = mem_model[return_addr[0]];
			void'(return_due.pop_front());
			void'(return_addr.pop_front());
		end else begin
			edge_data_in = '0;
		end
	end

	////////////////////////////////////////////////////////////
	// Compare process, sampled mid-cycle
	////////////////////////////////////////////////////////////

	always @(negedge clock) begin : compare
		pagerank_mem_pkg::read_cmd_t expected_cmd;
		int                          due;
		if (rstn) begin
			if (read_buffer_alfull && read_command_bus_request)
				note_failure("read command request high while read buffer almost full");
			if (read_command_bus_grant && !read_command_bus_request)
				note_failure("grant present without a read command request");
			if (read_command_bus_grant) begin
				if (exp_cmds.size() == 0) begin
					note_failure("read command taken while none was expected");
				end else begin
					expected_cmd = exp_cmds.pop_front();
					check_read_cmd(read_command_out, expected_cmd);
				end
				// One data beat per cycle, each 1 to 6 cycles after its grant
				due = cycle + $urandom_range(6, 1);
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				return_addr.push_back(read_command_out.address);
				return_due.push_back(due);
			end
			if (rank_write_out.valid && prev_write_valid)
				note_failure("rank write strobe stayed high for two cycles");
			if (rank_write_out.valid) begin
				if (exp_writes.size() == 0)
					note_failure("rank write arrived while none was expected");
				else
					check_rank_write(rank_write_out, exp_writes.pop_front());
			end
			prev_write_valid = rank_write_out.valid;
		end
	end

	always @(posedge clock) begin : watchdog
		cycle = cycle + 1;
		if (cycle > cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles, %0d rank writes missing",
				cycle_limit, exp_writes.size());
			$display("*** FAILED ***");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic send_jobs(input int first, input int count);
		pagerank_mem_pkg::read_cmd_t cmd;
		@(negedge clock);
		while (!vertex_job_request)
			@(negedge clock);
		for (int i = first; i < first + count; i++) begin
			@(posedge clock);
			#1;
			vertex_job = jobs[i];
			exp_writes.push_back(compute_rank_write(jobs[i]));
			for (int e = 0; e < jobs[i].out_degree; e++) begin
				cmd.valid   = 1'b1;
				cmd.address = jobs[i].edges_idx + e;
				cmd.tag     = jobs[i].vertex_id;
				exp_cmds.push_back(cmd);
			end
		end
		@(posedge clock);
		#1;
		vertex_job = '0;
	endtask

	task automatic wait_drained();
		while (exp_writes.size() != 0 || return_due.size() != 0)
			@(negedge clock);
		@(negedge clock);
	endtask

	task automatic report_test(input int num, input string name, input int errs_before);
		if (err_count == errs_before)
			$display("Test %0d %s: ok", num, name);
		else
			$display("Test %0d %s: %0d errors", num, name, err_count - errs_before);
	endtask

	initial begin : main
		int sum_deg;
		int errs_before;
		void'($urandom(48019));
		rstn                   = 1'b0;
		enabled_in             = 1'b1;
		vertex_job             = '0;
		read_buffer_alfull     = 1'b0;
		read_command_bus_grant = 1'b0;
		edge_data_in           = '0;

		for (int a = 0; a < MEM_DEPTH; a++)
			mem_model[a] = $urandom() ^ (32'(a) * 32'h9e37_79b9);
		jobs[0] = make_job(100, 4, 10);
		jobs[1] = make_job(101, 0, 50);
		for (int i = 2; i < 14; i++)
			jobs[i] = make_job(200 + i, $urandom_range(9, 0), $urandom_range(200, 0));
		jobs[14] = make_job(300, 9, 120);
		jobs[15] = make_job(301, 5, 30);
		sum_deg = 0;
		for (int i = 0; i < NUM_JOBS; i++)
			sum_deg += jobs[i].out_degree;
		cycle_limit = sum_deg * 12 + NUM_JOBS * 10 + 200;

		repeat (3) @(posedge clock);
		#1;
		rstn = 1'b1;

		errs_before = err_count;
		@(negedge clock);
		check_flag("vertex_job_request", vertex_job_request, 1'b1);
		check_flag("read_command_bus_request", read_command_bus_request, 1'b0);
		check_flag("rank_write_out.valid", rank_write_out.valid, 1'b0);
		check_count("vertex_num_counter", vertex_num_counter, 0);
		check_count("edge_num_counter", edge_num_counter, 0);
		report_test(1, "reset state", errs_before);

		errs_before = err_count;
		send_jobs(0, 1);
		wait_drained();
		report_test(2, "single vertex of degree 4", errs_before);

		errs_before = err_count;
		send_jobs(1, 1);
		wait_drained();
		report_test(3, "zero-degree vertex", errs_before);

		errs_before = err_count;
		send_jobs(2, 12);
		wait_drained();
		report_test(4, "twelve random vertices back to back", errs_before);

		// Hold the read buffer almost full while commands pile up
		errs_before = err_count;
		send_jobs(14, 2);
		alfull_cycles_left = 40;
		repeat (40) @(negedge clock);
		check_flag("read_command_out.valid", read_command_out.valid, 1'b1);
		wait_drained();
		report_test(5, "read buffer almost full for 40 cycles", errs_before);

		errs_before = err_count;
		check_count("vertex_num_counter", vertex_num_counter, NUM_JOBS);
		check_count("edge_num_counter", edge_num_counter, sum_deg);
		if (exp_cmds.size() != 0)
			note_failure("read commands expected but never issued");
		report_test(6, "final totals", errs_before);

		$display("Checks run: %0d, errors: %0d", checks_done, err_count);
		if (err_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- project.f
+incdir+.
pagerank_job_pkg.sv
pagerank_mem_pkg.sv
job_fifo.sv
edge_progress_counter.sv
rank_accumulator.sv
vertex_control_fsm.sv
cu_vertex_pagerank.sv
cu_vertex_pagerank_assert.sv
tb_cu_vertex_pagerank.sv
